//--- Bender.yml
package:
  name: blimp

sources:
  - source/blimp_pkg.sv
  - source/fetch_unit.sv
  - source/decode_unit.sv
  - source/reg_file.sv
  - source/execute_unit.sv
  - source/core_ctrl.sv
  - source/blimp_core.sv
  - target: test
    files:
      - test/blimp_checker.sv
      - test/blimp_assertions.sv
      - test/blimp_tb.sv

//--- blimp.f
source/blimp_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/core_ctrl.sv
source/blimp_core.sv
test/blimp_checker.sv
test/blimp_assertions.sv
test/blimp_tb.sv

//--- source/blimp_core.sv
//------------------------------------------------------------
// Blimp core top level
// Control FSM with fetch, decode, register file and execute
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module blimp_core import blimp_pkg::*; #(
  parameter int p_opaq_bits = 8
) (
  input  logic                     clk,
  input  logic                     reset,
  // Instruction memory port
  output logic                     mem_req,
  output logic [xlen-1:0]          mem_addr,
  output logic [p_opaq_bits-1:0]   mem_req_opaq,
  input  logic                     mem_ack,
  input  logic [xlen-1:0]          mem_data,
  input  logic [p_opaq_bits-1:0]   mem_resp_opaq,
  // Instruction trace
  output logic                     trace_val,
  output logic [xlen-1:0]          trace_pc,
  output logic [reg_addr_bits-1:0] trace_waddr,
  output logic [xlen-1:0]          trace_wdata,
  output logic                     trace_wen,
  output logic                     fetch_error
);

  // Control
  logic                     fetch_start;
  logic                     fetch_done;
  logic                     exec_en;
  logic                     pc_next_req;
  // Fetched instruction
  logic [xlen-1:0]          inst;
  logic [xlen-1:0]          inst_pc;
  // Decode outputs
  logic [reg_addr_bits-1:0] rs1;
  logic [reg_addr_bits-1:0] rs2;
  logic [reg_addr_bits-1:0] rd;
  logic [xlen-1:0]          imm;
  logic                     use_imm;
  alu_op_t                  alu_op;
  logic                     legal;
  // Register file
  logic [xlen-1:0]          rs1_data;
  logic [xlen-1:0]          rs2_data;
  logic                     wb_en;
  logic [reg_addr_bits-1:0] wb_addr;
  logic [xlen-1:0]          wb_data;

  core_ctrl i_ctrl (
    .clk, .reset, .fetch_done, .pc_next_req, .fetch_start, .exec_en
  );

  fetch_unit #(
    .p_opaq_bits (p_opaq_bits)
  ) i_fetch (
    .clk, .reset, .fetch_start,
    .mem_req, .mem_addr, .mem_req_opaq,
    .mem_ack, .mem_data, .mem_resp_opaq,
    .fetch_done, .inst, .inst_pc, .fetch_error
  );

  decode_unit i_decode (
    .inst, .rs1, .rs2, .rd, .imm, .use_imm, .alu_op, .legal
  );

  reg_file i_regs (
    .clk, .reset, .rs1, .rs2, .rs1_data, .rs2_data, .wb_en, .wb_addr, .wb_data
  );

  execute_unit i_exec (
    .clk, .reset, .exec_en, .inst_pc, .rs1_data, .rs2_data,
    .imm, .use_imm, .alu_op, .legal, .rd,
    .wb_en, .wb_addr, .wb_data, .pc_next_req,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen
  );

endmodule

`default_nettype wire

//--- source/blimp_pkg.sv
//------------------------------------------------------------
// Blimp core definitions
// Widths, RV32 opcode and funct encodings, ALU operations
//------------------------------------------------------------

`default_nettype none

package blimp_pkg;

  // Data and address width, one word
  localparam int xlen          = 32;
  localparam int reg_addr_bits = 5;

  // Major opcodes of the subset
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;

  // funct3 field values
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7 field values
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;

  // ALU operations
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_t;

endpackage

`default_nettype wire

//--- source/core_ctrl.sv
//------------------------------------------------------------
// Core control
// Fetch, decode, execute sequencing, one instruction at a time
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module core_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic fetch_done,
  input  logic pc_next_req,
  output logic fetch_start,
  output logic exec_en
);

  typedef enum logic [1:0] {
    st_fetch,
    st_decode,
    st_execute
  } state_t;

  state_t state_q;
  state_t state_d;
  // High in the first cycle of the fetch state
  logic   entry_q;

  //------------------------------------------------------------
  // Next state
  //------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_fetch: begin
        // Wait out a variable-latency fetch
        if (fetch_done)
          state_d = st_decode;
      end
      st_decode:
        state_d = st_execute;
      st_execute: begin
        if (pc_next_req)
          state_d = st_fetch;
      end
      default:
        state_d = st_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // Start fetching right out of reset
      state_q <= st_fetch;
      entry_q <= 1'b1;
    end else begin
      state_q <= state_d;
      entry_q <= (state_q != st_fetch) && (state_d == st_fetch);
    end
  end

  assign fetch_start = entry_q;
  // Operands valid during the decode cycle
  assign exec_en     = (state_q == st_decode);

endmodule

`default_nettype wire

//--- source/decode_unit.sv
//------------------------------------------------------------
// Instruction decode
// Register fields, immediates, ALU operation and legality
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module decode_unit import blimp_pkg::*; (
  input  logic [xlen-1:0]          inst,
  output logic [reg_addr_bits-1:0] rs1,
  output logic [reg_addr_bits-1:0] rs2,
  output logic [reg_addr_bits-1:0] rd,
  output logic [xlen-1:0]          imm,
  output logic                     use_imm,
  output alu_op_t                  alu_op,
  output logic                     legal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Fixed RV32 field positions
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  always_comb begin
    imm     = {{20{inst[31]}}, inst[31:20]};
    use_imm = 1'b0;
    alu_op  = alu_add;
    legal   = 1'b0;
    case (opcode)
      op_reg: begin
        // Only SUB uses the alternate funct7
        case (funct3)
          f3_add_sub: begin
            alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
            legal  = (funct7 == f7_base) || (funct7 == f7_sub);
          end
          f3_and: begin
            alu_op = alu_and;
            legal  = (funct7 == f7_base);
          end
          f3_or: begin
            alu_op = alu_or;
            legal  = (funct7 == f7_base);
          end
          f3_xor: begin
            alu_op = alu_xor;
            legal  = (funct7 == f7_base);
          end
          default: legal = 1'b0;
        endcase
      end
      op_imm: begin
        // ADDI only
        use_imm = 1'b1;
        legal   = (funct3 == f3_add_sub);
      end
      op_lui: begin
        imm     = {inst[31:12], 12'b0};
        use_imm = 1'b1;
        alu_op  = alu_pass_b;
        legal   = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/execute_unit.sv
//------------------------------------------------------------
// Execute stage
// ALU, register writeback and the retired-instruction trace
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module execute_unit import blimp_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     exec_en,
  input  logic [xlen-1:0]          inst_pc,
  input  logic [xlen-1:0]          rs1_data,
  input  logic [xlen-1:0]          rs2_data,
  input  logic [xlen-1:0]          imm,
  input  logic                     use_imm,
  input  alu_op_t                  alu_op,
  input  logic                     legal,
  input  logic [reg_addr_bits-1:0] rd,
  output logic                     wb_en,
  output logic [reg_addr_bits-1:0] wb_addr,
  output logic [xlen-1:0]          wb_data,
  output logic                     pc_next_req,
  output logic                     trace_val,
  output logic [xlen-1:0]          trace_pc,
  output logic [reg_addr_bits-1:0] trace_waddr,
  output logic [xlen-1:0]          trace_wdata,
  output logic                     trace_wen
);

  logic [xlen-1:0] op_b;
  logic [xlen-1:0] result;
  logic            writes_rd;

  assign op_b = use_imm ? imm : rs2_data;

  always_comb begin
    case (alu_op)
      alu_add:    result = rs1_data + op_b;
      alu_sub:    result = rs1_data - op_b;
      alu_and:    result = rs1_data & op_b;
      alu_or:     result = rs1_data | op_b;
      alu_xor:    result = rs1_data ^ op_b;
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

  // Illegal encodings and x0 targets retire without a write
  assign writes_rd = legal && (rd != '0);

  // Commit at the end of the exec_en cycle
  assign wb_en   = exec_en && writes_rd;
  assign wb_addr = rd;
  assign wb_data = result;

  //------------------------------------------------------------
  // Trace, one cycle after exec_en
  //------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      trace_val <= 1'b0;
    else
      trace_val <= exec_en;
  end

  always_ff @(posedge clk) begin
    if (exec_en) begin
      trace_pc    <= inst_pc;
      trace_waddr <= rd;
      trace_wdata <= result;
      trace_wen   <= writes_rd;
    end
  end

  // Retire pulse lets control move on to the next fetch
  assign pc_next_req = trace_val;

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
//------------------------------------------------------------
// Instruction fetch
// Four-phase request master, owns the pc and the tag counter
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module fetch_unit import blimp_pkg::*; #(
  parameter int p_opaq_bits = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_start,
  output logic                   mem_req,
  output logic [xlen-1:0]        mem_addr,
  output logic [p_opaq_bits-1:0] mem_req_opaq,
  input  logic                   mem_ack,
  input  logic [xlen-1:0]        mem_data,
  input  logic [p_opaq_bits-1:0] mem_resp_opaq,
  output logic                   fetch_done,
  output logic [xlen-1:0]        inst,
  output logic [xlen-1:0]        inst_pc,
  output logic                   fetch_error
);

  logic [xlen-1:0]        pc;
  logic [p_opaq_bits-1:0] tag;
  // Fetch requested but ack not yet released
  logic                   pending;

  // Request and address come straight from the registers
  assign mem_addr     = pc;
  assign mem_req_opaq = tag;

  //------------------------------------------------------------
  // Handshake control
  //------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_req     <= 1'b0;
      pending     <= 1'b0;
      pc          <= '0;
      tag         <= '0;
      fetch_done  <= 1'b0;
      fetch_error <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      if (mem_req) begin
        // Phase 2 seen, drop request and advance
        if (mem_ack) begin
          mem_req    <= 1'b0;
          pc         <= pc + xlen'(4);
          tag        <= tag + 1'b1;
          fetch_done <= 1'b1;
          // Sticky, core keeps running
          if (mem_resp_opaq != tag)
            fetch_error <= 1'b1;
        end
      end else if ((pending || fetch_start) && !mem_ack) begin
        mem_req <= 1'b1;
        pending <= 1'b0;
      end else if (fetch_start) begin
        // Previous ack still high, hold off
        pending <= 1'b1;
      end
    end
  end

  // Instruction and its pc, latched with the ack
  always_ff @(posedge clk) begin
    if (mem_req && mem_ack) begin
      inst    <= mem_data;
      inst_pc <= pc;
    end
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
//------------------------------------------------------------
// Register file
// 32 x 32-bit, two async reads, one sync write, x0 is zero
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module reg_file import blimp_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [reg_addr_bits-1:0] rs1,
  input  logic [reg_addr_bits-1:0] rs2,
  output logic [xlen-1:0]          rs1_data,
  output logic [xlen-1:0]          rs2_data,
  input  logic                     wb_en,
  input  logic [reg_addr_bits-1:0] wb_addr,
  input  logic [xlen-1:0]          wb_data
);

  logic [xlen-1:0] regs [0:(1<<reg_addr_bits)-1];

  // Write port, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < (1 << reg_addr_bits); i++)
        regs[i] <= '0;
    end else if (wb_en && (wb_addr != '0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // Read ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- test/blimp_assertions.sv
//------------------------------------------------------------
// Blimp core assertions
// Four-phase handshake rules and reset state
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module blimp_assertions import blimp_pkg::*; (
  input logic            clk,
  input logic            reset,
  input logic            mem_req,
  input logic            mem_ack,
  input logic [xlen-1:0] mem_addr,
  input logic            trace_val
);

  int fail_count = 0;

  // New request only once the previous ack was seen low
  req_after_ack_low: assert property (
    @(posedge clk) disable iff (reset) $rose(mem_req) |-> !$past(mem_ack)
  ) else begin
    fail_count++;
    $error("mem_req rose while mem_ack was still high");
  end

  // Address held for the whole request
  addr_stable: assert property (
    @(posedge clk) disable iff (reset) (mem_req && $past(mem_req)) |-> $stable(mem_addr)
  ) else begin
    fail_count++;
    $error("mem_addr changed while mem_req was high");
  end

  // Quiet core right out of reset
  reset_quiet: assert property (
    @(posedge clk) $fell(reset) |-> (!mem_req && !trace_val)
  ) else begin
    fail_count++;
    $error("mem_req or trace_val high in the first cycle after reset");
  end

endmodule

bind blimp_core blimp_assertions i_assertions (
  .clk, .reset, .mem_req, .mem_ack, .mem_addr, .trace_val
);

`default_nettype wire

//--- test/blimp_checker.sv
//------------------------------------------------------------
// Blimp core checker
// ISA model of the subset, compares every retired trace
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module blimp_checker import blimp_pkg::*; #(
  parameter int p_opaq_bits = 8,
  parameter int p_group_len = 64,
  parameter int p_num_tests = 5
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     mem_req,
  input  logic [xlen-1:0]          mem_addr,
  input  logic [p_opaq_bits-1:0]   mem_req_opaq,
  input  logic                     mem_ack,
  input  logic [xlen-1:0]          mem_data,
  input  logic [p_opaq_bits-1:0]   mem_resp_opaq,
  input  logic                     trace_val,
  input  logic [xlen-1:0]          trace_pc,
  input  logic [reg_addr_bits-1:0] trace_waddr,
  input  logic [xlen-1:0]          trace_wdata,
  input  logic                     trace_wen,
  input  logic                     fetch_error,
  output int                       test_idx,
  output logic                     done,
  output int                       check_count,
  output int                       error_count
);

  logic [xlen-1:0]        model_regs [0:31];
  logic [xlen-1:0]        exp_pc;
  logic [xlen-1:0]        exp_addr;
  logic [p_opaq_bits-1:0] exp_tag;
  logic                   exp_error;
  logic                   req_q;
  logic                   reset_pending;
  // Instructions handed over but not yet retired
  logic [xlen-1:0]        fetched [$];
  int                     retired;
  int                     test_checks;
  int                     test_errors;

  initial begin
    test_idx    = 0;
    done        = 1'b0;
    check_count = 0;
    error_count = 0;
    test_checks = 0;
    test_errors = 0;
    retired     = 0;
  end

  function automatic string test_name(int idx);
    case (idx)
      0:       return "reset_state";
      1:       return "fetch_no_delay";
      2:       return "fetch_random_delay";
      3:       return "fetch_slow_release";
      4:       return "tag_check";
      default: return "unknown";
    endcase
  endfunction

  task automatic expect_equal(input string what, input logic [xlen-1:0] exp_val,
                              input logic [xlen-1:0] act_val);
    check_count++;
    test_checks++;
    if (act_val !== exp_val) begin
      error_count++;
      test_errors++;
      $display("ERROR %s: %s expected %h actual %h", test_name(test_idx), what,
               exp_val, act_val);
    end
  endtask

  task automatic report_problem(input string what);
    error_count++;
    test_errors++;
    $display("Test %s: %s", test_name(test_idx), what);
  endtask

  //------------------------------------------------------------
  // ISA model, RV32 field rules of the subset
  //------------------------------------------------------------
  task automatic model_execute(input logic [xlen-1:0] inst, output logic legal,
                               output logic [xlen-1:0] value);
    logic [6:0]      opcode;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    opcode = inst[6:0];
    f3     = inst[14:12];
    f7     = inst[31:25];
    a      = model_regs[inst[19:15]];
    b      = model_regs[inst[24:20]];
    legal  = 1'b0;
    value  = '0;
    if (opcode == op_reg && f7 == f7_base) begin
      legal = 1'b1;
      case (f3)
        f3_add_sub: value = a + b;
        f3_and:     value = a & b;
        f3_or:      value = a | b;
        f3_xor:     value = a ^ b;
        default:    legal = 1'b0;
      endcase
    end else if (opcode == op_reg && f7 == f7_sub && f3 == f3_add_sub) begin
      legal = 1'b1;
      value = a - b;
    end else if (opcode == op_imm && f3 == f3_add_sub) begin
      // ADDI, sign-extended 12-bit immediate
      legal = 1'b1;
      value = a + {{20{inst[31]}}, inst[31:20]};
    end else if (opcode == op_lui) begin
      legal = 1'b1;
      value = {inst[31:12], 12'b0};
    end
  endtask

  task automatic finish_test();
    // Bad tag was sent during the last test
    if (test_idx == p_num_tests - 1)
      expect_equal("fetch_error at end of run", 1, fetch_error);
    $display("Test %0d %s: %0d checks, %0d errors", test_idx, test_name(test_idx),
             test_checks, test_errors);
    test_idx++;
    test_checks = 0;
    test_errors = 0;
    retired     = 0;
    if (test_idx == p_num_tests)
      done = 1'b1;
  endtask

  task automatic retire();
    logic [xlen-1:0]          inst;
    logic                     legal;
    logic [xlen-1:0]          value;
    logic [reg_addr_bits-1:0] rd;
    if (fetched.size() != 1) begin
      report_problem($sformatf("trace_val with %0d fetched instructions waiting",
                               fetched.size()));
    end
    if (fetched.size() != 0) begin
      inst = fetched.pop_front();
      rd   = inst[11:7];
      model_execute(inst, legal, value);
      expect_equal("trace_pc", exp_pc, trace_pc);
      // x0 targets and illegal encodings retire without a write
      expect_equal("trace_wen", legal && (rd != 0), trace_wen);
      if (legal) begin
        expect_equal("trace_waddr", rd, trace_waddr);
        expect_equal("trace_wdata", value, trace_wdata);
        if (rd != 0)
          model_regs[rd] = value;
      end
    end
    exp_pc = exp_pc + 4;
    expect_equal("fetch_error", exp_error, fetch_error);
    retired++;
    if (retired == p_group_len)
      finish_test();
  endtask

  // DUT outputs sampled at the rising edge, before they update
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        model_regs[i] = '0;
      exp_pc        = '0;
      exp_addr      = '0;
      exp_tag       = '0;
      exp_error     = 1'b0;
      req_q         = 1'b0;
      reset_pending = 1'b1;
      fetched.delete();
    end else if (!done) begin
      if (reset_pending) begin
        expect_equal("mem_req after reset", 0, mem_req);
        expect_equal("trace_val after reset", 0, trace_val);
        expect_equal("fetch_error after reset", 0, fetch_error);
        reset_pending = 1'b0;
      end
      // New request, address and tag both step by one
      if (mem_req && !req_q) begin
        expect_equal("request address", exp_addr, mem_addr);
        expect_equal("request tag", exp_tag, mem_req_opaq);
        exp_addr = exp_addr + 4;
        exp_tag  = exp_tag + 1'b1;
        if (test_idx == 0)
          finish_test();
      end
      // Handshake completes, error flag is sticky
      if (mem_req && mem_ack) begin
        fetched.push_back(mem_data);
        if (mem_resp_opaq != mem_req_opaq)
          exp_error = 1'b1;
      end
      if (trace_val)
        retire();
      req_q = mem_req;
    end
  end

endmodule

`default_nettype wire

//--- test/blimp_tb.sv
//------------------------------------------------------------
// Blimp core testbench
// Random program, four-phase memory responder, watchdog
//------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module blimp_tb import blimp_pkg::*; ();

  localparam int opaq_bits    = 8;
  localparam int clk_period   = 40;
  localparam int reset_cycles = 10;
  localparam int group_len    = 64;
  localparam int num_tests    = 5;
  // Every test but the reset one retires a full group
  localparam int num_instr    = (num_tests - 1) * group_len;

  logic                     clk;
  logic                     reset;
  logic                     mem_req;
  logic [xlen-1:0]          mem_addr;
  logic [opaq_bits-1:0]     mem_req_opaq;
  logic                     mem_ack;
  logic [xlen-1:0]          mem_data;
  logic [opaq_bits-1:0]     mem_resp_opaq;
  logic                     trace_val;
  logic [xlen-1:0]          trace_pc;
  logic [reg_addr_bits-1:0] trace_waddr;
  logic [xlen-1:0]          trace_wdata;
  logic                     trace_wen;
  logic                     fetch_error;
  // Checker status
  int                       test_idx;
  logic                     done;
  int                       check_count;
  int                       error_count;

  // 64-word instruction memory
  logic [xlen-1:0]          prog [0:63];

  blimp_core #(
    .p_opaq_bits (opaq_bits)
  ) i_dut (
    .clk, .reset,
    .mem_req, .mem_addr, .mem_req_opaq, .mem_ack, .mem_data, .mem_resp_opaq,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen, .fetch_error
  );

  blimp_checker #(
    .p_opaq_bits (opaq_bits),
    .p_group_len (group_len),
    .p_num_tests (num_tests)
  ) i_checker (
    .clk, .reset,
    .mem_req, .mem_addr, .mem_req_opaq, .mem_ack, .mem_data, .mem_resp_opaq,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen, .fetch_error,
    .test_idx, .done, .check_count, .error_count
  );

  //------------------------------------------------------------
  // RV32 encoders
  //------------------------------------------------------------
  function automatic logic [xlen-1:0] r_type(logic [6:0] f7, logic [4:0] rs2,
                                              logic [4:0] rs1, logic [2:0] f3,
                                              logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [xlen-1:0] i_type(logic [11:0] imm, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
    return {imm, rs1, f3, rd, op_imm};
  endfunction

  // One random instruction, about one in five illegal
  function automatic logic [xlen-1:0] random_instr();
    int unsigned     kind;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] word;
    logic [xlen-1:0] raw;
    kind = $urandom % 16;
    // Few registers so results feed each other, x0 included
    rd   = $urandom % 8;
    rs1  = $urandom % 8;
    rs2  = $urandom % 8;
    raw  = $urandom;
    case (kind)
      0, 1, 14: word = r_type(f7_base, rs2, rs1, f3_add_sub, rd);
      2:        word = r_type(f7_sub, rs2, rs1, f3_add_sub, rd);
      3:        word = r_type(f7_base, rs2, rs1, f3_and, rd);
      4:        word = r_type(f7_base, rs2, rs1, f3_or, rd);
      5:        word = r_type(f7_base, rs2, rs1, f3_xor, rd);
      6, 7, 8:  word = i_type(raw[11:0], rs1, f3_add_sub, rd);
      9, 10:    word = {raw[31:12], rd, op_lui};
      // Custom-0 opcode, outside the subset
      11:       word = {raw[31:7], 7'b0001011};
      // MUL encoding
      12:       word = r_type(7'b0000001, rs2, rs1, f3_add_sub, rd);
      // Shift-immediate funct3
      13:       word = i_type(raw[11:0], rs1, 3'b001, rd);
      default:  word = i_type(raw[11:0], rs1, f3_add_sub, rd);
    endcase
    return word;
  endfunction

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //------------------------------------------------------------
  // Memory responder, inputs change on the falling edge
  //------------------------------------------------------------
  initial begin : responder
    int unsigned wait_cycles;
    int unsigned ack_max;
    int unsigned rel_max;
    int unsigned tag_fetches;
    mem_ack       = 1'b0;
    mem_data      = '0;
    mem_resp_opaq = '0;
    tag_fetches   = 0;
    wait (reset === 1'b0);
    forever begin
      @(negedge clk);
      if (mem_req === 1'b1 && !mem_ack) begin
        // Delay profile of the running test
        case (test_idx)
          1:       begin ack_max = 0; rel_max = 0; end
          3:       begin ack_max = 3; rel_max = 6; end
          default: begin ack_max = 3; rel_max = 3; end
        endcase
        wait_cycles = $urandom % (ack_max + 1);
        repeat (wait_cycles) @(negedge clk);
        // Word index wraps over the 64-word memory
        mem_data      = prog[mem_addr[7:2]];
        mem_resp_opaq = mem_req_opaq;
        if (test_idx == num_tests - 1) begin
          tag_fetches++;
          // Single bad tag in the last test
          if (tag_fetches == 4)
            mem_resp_opaq = ~mem_req_opaq;
        end
        mem_ack = 1'b1;
        while (mem_req) @(negedge clk);
        wait_cycles = $urandom % (rel_max + 1);
        repeat (wait_cycles) @(negedge clk);
        mem_ack = 1'b0;
      end
    end
  end

  //------------------------------------------------------------
  // Reset, program load and summary
  //------------------------------------------------------------
  initial begin : main
    int unsigned seed_ret;
    int          total_errors;
    seed_ret = $urandom(32'h572b);
    reset    = 1'b1;
    for (int i = 0; i < 64; i++)
      prog[i] = random_instr();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    wait (done === 1'b1);
    @(negedge clk);
    total_errors = error_count + i_dut.i_assertions.fail_count;
    $display("Summary: %0d tests, %0d checks, %0d check errors, %0d assertion failures",
             num_tests, check_count, error_count, i_dut.i_assertions.fail_count);
    if (total_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // Twelve cycles per instruction is well above the slowest profile
  initial begin : watchdog
    repeat (num_instr * 12 + reset_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles, core stopped retiring",
             num_instr * 12 + reset_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
